// File: source/csb_fifo_pkg.sv
// ====================
// sizes and shared types for the control-bus master FIFO
// ====================

package csb_fifo_pkg;

    // ====================
    // sizes
    // ====================

    // number of flop RAM entries
    localparam int FIFO_DEPTH = 4;

    // payload width of one control-bus word
    localparam int DATA_W = 50;

    // RAM address width, log2 of depth
    localparam int ADR_W = 2;

    // count width, must also hold FIFO_DEPTH itself
    localparam int CNT_W = 3;

    // ====================
    // types
    // ====================

    typedef logic [DATA_W-1:0] fifo_data_t;
    typedef logic [ADR_W-1:0]  fifo_adr_t;
    typedef logic [CNT_W-1:0]  fifo_cnt_t;

endpackage

// File: source/fifo_wr_ctrl.sv
// ====================
// write admission, busy flags, write-side count, limit and write address
// ====================

module fifo_wr_ctrl (
    input  logic                     rd_clk_rd_mgated,
    input  logic                     wr_reset_,
    input  logic                     wr_req,
    input  csb_fifo_pkg::fifo_cnt_t  wr_limit,
    input  logic                     rd_popping,
    output logic                     wr_ready,
    output logic                     ram_iwe,
    output logic                     wr_pushing,
    output csb_fifo_pkg::fifo_adr_t  wr_adr
);
    import csb_fifo_pkg::*;

    // registered request, waits here while busy
    logic      wr_req_in;
    // input side held this cycle
    logic      wr_busy_in;
    // internal busy copy
    logic      wr_busy_int;
    logic      wr_busy_in_int;
    logic      wr_busy_next;
    logic      wr_busy_in_next;
    logic      wr_busy_in_next_req;
    logic      wr_busy_in_next_no_req;
    logic      wr_reserving;

    fifo_cnt_t wr_count;
    fifo_cnt_t wr_count_next_pop;
    fifo_cnt_t wr_count_next_no_pop;
    fifo_cnt_t wr_count_next;
    logic      wr_count_next_is_full;
    logic      wr_limit_hit;

    // ====================
    // admission
    // ====================

    assign wr_ready = !wr_busy_in;

    // capture data into the RAM input register on acceptance
    assign ram_iwe = wr_req && !wr_busy_in;

    // waiting request blocked by a busy fifo
    assign wr_busy_in_int = wr_req_in && wr_busy_int;

    // registered request meets free space
    assign wr_reserving = wr_req_in && !wr_busy_int;

    // the RAM entry is written in the reserving cycle
    assign wr_pushing = wr_reserving;

    // split on wr_req, it arrives late in the cycle
    assign wr_busy_in_next_req    = wr_busy_next;
    assign wr_busy_in_next_no_req = wr_req_in && wr_busy_next && !wr_reserving;
    assign wr_busy_in_next = wr_req ? wr_busy_in_next_req : wr_busy_in_next_no_req;

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            wr_req_in  <= 1'b0;
            wr_busy_in <= 1'b0;
        end else begin
            wr_busy_in <= wr_busy_in_next;
            // hold a waiting request until space frees up
            if (!wr_busy_in_int) begin
                wr_req_in <= wr_req && !wr_busy_in;
            end
        end
    end

    // ====================
    // count and limit
    // ====================

    assign wr_count_next_pop    = wr_reserving ? wr_count : (wr_count - CNT_W'(1));
    assign wr_count_next_no_pop = wr_reserving ? (wr_count + CNT_W'(1)) : wr_count;
    assign wr_count_next        = rd_popping ? wr_count_next_pop : wr_count_next_no_pop;

    // a pop can never leave the count at full depth
    assign wr_count_next_is_full = !rd_popping &&
                                   (wr_count_next_no_pop == CNT_W'(FIFO_DEPTH));

    // limit of zero means full depth
    assign wr_limit_hit = (wr_limit != '0) && (wr_count_next >= wr_limit);

    assign wr_busy_next = wr_count_next_is_full || wr_limit_hit;

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            wr_busy_int <= 1'b0;
            wr_count    <= '0;
        end else begin
            wr_busy_int <= wr_busy_next;
            // reserve and pop together leave the count as is
            if (wr_reserving ^ rd_popping) begin
                wr_count <= wr_count_next;
            end
        end
    end

    // ====================
    // write address
    // ====================

    // wraps naturally at depth 4
    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            wr_adr <= '0;
        end else if (wr_pushing) begin
            wr_adr <= wr_adr + ADR_W'(1);
        end
    end

endmodule

// File: source/fifo_flop_ram.sv
// ====================
// four-entry flop RAM with input data register
// ====================

module fifo_flop_ram (
    input  logic                      rd_clk_rd_mgated,
    input  csb_fifo_pkg::fifo_data_t  wr_data,
    input  logic                      ram_iwe,
    input  logic                      wr_pushing,
    input  csb_fifo_pkg::fifo_adr_t   wr_adr,
    input  csb_fifo_pkg::fifo_adr_t   rd_adr,
    output csb_fifo_pkg::fifo_data_t  ram_rd_data
);
    import csb_fifo_pkg::*;

    // input word, held while a request waits
    fifo_data_t di_d;

    // storage entries
    fifo_data_t ram_ff [FIFO_DEPTH];

    // ====================
    // write path
    // ====================

    // loads in the accept cycle
    always_ff @(posedge rd_clk_rd_mgated) begin
        if (ram_iwe) begin
            di_d <= wr_data;
        end
    end

    // entry written one cycle after acceptance, or later if the request waited
    always_ff @(posedge rd_clk_rd_mgated) begin
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            if (wr_pushing && (wr_adr == ADR_W'(i))) begin
                ram_ff[i] <= di_d;
            end
        end
    end

    // ====================
    // read path
    // ====================

    // plain mux, no read register
    always_comb begin
        ram_rd_data = ram_ff[0];
        for (int i = 1; i < FIFO_DEPTH; i++) begin
            if (rd_adr == ADR_W'(i)) begin
                ram_rd_data = ram_ff[i];
            end
        end
    end

endmodule

// File: source/fifo_rd_stage.sv
// ====================
// read-side count and address, output valid and data register
// ====================

module fifo_rd_stage (
    input  logic                      rd_clk_rd_mgated,
    input  logic                      wr_reset_,
    input  logic                      wr_pushing,
    input  csb_fifo_pkg::fifo_data_t  ram_rd_data,
    input  logic                      rd_ready,
    output logic                      rd_popping,
    output csb_fifo_pkg::fifo_adr_t   rd_adr,
    output logic                      rd_req,
    output csb_fifo_pkg::fifo_data_t  rd_data
);
    import csb_fifo_pkg::*;

    // push notice, one cycle after the RAM write
    logic      rd_pushing;
    // entries visible to the read side
    fifo_cnt_t rd_count_p;
    fifo_cnt_t rd_count_p_next;
    // an entry can be popped this cycle
    logic      rd_req_p;
    logic      rd_req_next;

    // ====================
    // push notice
    // ====================

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            rd_pushing <= 1'b0;
        end else begin
            rd_pushing <= wr_pushing;
        end
    end

    // ====================
    // count and address
    // ====================

    assign rd_req_p = (rd_count_p != '0) || rd_pushing;

    // pop unless the output register is full and stalled
    assign rd_popping = rd_req_p && !(rd_req && !rd_ready);

    always_comb begin
        case ({rd_pushing, rd_popping})
            2'b10:   rd_count_p_next = rd_count_p + CNT_W'(1);
            2'b01:   rd_count_p_next = rd_count_p - CNT_W'(1);
            default: rd_count_p_next = rd_count_p;
        endcase
    end

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            rd_count_p <= '0;
            rd_adr     <= '0;
        end else begin
            rd_count_p <= rd_count_p_next;
            if (rd_popping) begin
                rd_adr <= rd_adr + ADR_W'(1);
            end
        end
    end

    // ====================
    // output stage
    // ====================

    // stays up while the consumer stalls
    assign rd_req_next = rd_req_p || (rd_req && !rd_ready);

    always_ff @(posedge rd_clk_rd_mgated or negedge wr_reset_) begin
        if (!wr_reset_) begin
            rd_req <= 1'b0;
        end else begin
            rd_req <= rd_req_next;
        end
    end

    // data only moves on a pop, so it holds under back-pressure
    always_ff @(posedge rd_clk_rd_mgated) begin
        if (rd_popping) begin
            rd_data <= ram_rd_data;
        end
    end

endmodule

// File: source/csb_fifo_top.sv
// ====================
// FIFO top level
// write control, flop RAM and read output stage
// ====================

module csb_fifo_top (
    input  logic                      rd_clk_rd_mgated,
    input  logic                      wr_reset_,
    // write side
    input  logic                      wr_req,
    input  csb_fifo_pkg::fifo_data_t  wr_data,
    input  csb_fifo_pkg::fifo_cnt_t   wr_limit,
    output logic                      wr_ready,
    // read side
    input  logic                      rd_ready,
    output logic                      rd_req,
    output csb_fifo_pkg::fifo_data_t  rd_data
);
    import csb_fifo_pkg::*;

    // write control to RAM and read stage
    logic       ram_iwe;
    logic       wr_pushing;
    fifo_adr_t  wr_adr;

    // read stage to RAM and write control
    logic       rd_popping;
    fifo_adr_t  rd_adr;
    fifo_data_t ram_rd_data;

    // ====================
    // write side
    // ====================

    fifo_wr_ctrl u_wr_ctrl (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .wr_reset_        (wr_reset_),
        .wr_req           (wr_req),
        .wr_limit         (wr_limit),
        .rd_popping       (rd_popping),
        .wr_ready         (wr_ready),
        .ram_iwe          (ram_iwe),
        .wr_pushing       (wr_pushing),
        .wr_adr           (wr_adr)
    );

    // flop RAM, data register in front of the entries
    fifo_flop_ram u_ram (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .wr_data          (wr_data),
        .ram_iwe          (ram_iwe),
        .wr_pushing       (wr_pushing),
        .wr_adr           (wr_adr),
        .rd_adr           (rd_adr),
        .ram_rd_data      (ram_rd_data)
    );

    // ====================
    // read side
    // ====================

    // push notice is delayed inside, pop notice goes back directly
    fifo_rd_stage u_rd_stage (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .wr_reset_        (wr_reset_),
        .wr_pushing       (wr_pushing),
        .ram_rd_data      (ram_rd_data),
        .rd_ready         (rd_ready),
        .rd_popping       (rd_popping),
        .rd_adr           (rd_adr),
        .rd_req           (rd_req),
        .rd_data          (rd_data)
    );

endmodule

// File: tests/csb_fifo_assertions.sv
// ====================
// bound checks on FIFO ports and write-side count
// ====================

module csb_fifo_assertions (
    input  logic                      rd_clk_rd_mgated,
    input  logic                      wr_reset_,
    input  logic                      wr_ready,
    input  logic                      rd_req,
    input  logic                      rd_ready,
    input  csb_fifo_pkg::fifo_data_t  rd_data,
    input  csb_fifo_pkg::fifo_cnt_t   wr_count
);
    import csb_fifo_pkg::*;

    // number of failed assertions
    int fail_count = 0;

    // first edge out of reset sees the output empty and the input open
    reset_exit_state: assert property (@(posedge rd_clk_rd_mgated)
        $rose(wr_reset_) |-> (!rd_req && wr_ready))
        else begin
            $error("rd_req or wr_ready wrong in the first cycle after reset");
            fail_count++;
        end

    // consumer stall holds the output word
    stall_holds_output: assert property (@(posedge rd_clk_rd_mgated) disable iff (!wr_reset_)
        (rd_req && !rd_ready) |=> (rd_req && $stable(rd_data)))
        else begin
            $error("rd_req or rd_data changed while the consumer stalled");
            fail_count++;
        end

    // reserved entries never exceed the RAM
    count_in_range: assert property (@(posedge rd_clk_rd_mgated) disable iff (!wr_reset_)
        wr_count <= CNT_W'(FIFO_DEPTH))
        else begin
            $error("write-side count above FIFO depth");
            fail_count++;
        end

endmodule

bind csb_fifo_top csb_fifo_assertions u_assertions (
    .rd_clk_rd_mgated (rd_clk_rd_mgated),
    .wr_reset_        (wr_reset_),
    .wr_ready         (wr_ready),
    .rd_req           (rd_req),
    .rd_ready         (rd_ready),
    .rd_data          (rd_data),
    .wr_count         (u_wr_ctrl.wr_count)
);

// File: tests/csb_fifo_tb.sv
// ====================
// testbench for the control-bus FIFO
// random traffic, queue model, stall, reset and drain phases
// ====================

module csb_fifo_tb;
    import csb_fifo_pkg::*;

    // ====================
    // run lengths
    // ====================

    localparam int RESET_CYCLES   = 2;
    localparam int PHASE_A_CYCLES = 400;
    localparam int PHASE_B_CYCLES = 300;
    localparam int STALL_CYCLES   = 40;
    // wr_ready must be low from here on in a stall
    localparam int STALL_CHECK    = 20;
    localparam int FILL_CYCLES    = 20;
    localparam int TAIL_CYCLES    = 100;
    localparam int DRAIN_CYCLES   = 50;
    // one drain each for A, three of B, four of C and the tail
    localparam int NUM_PHASES     = 9;
    localparam int TEST_CYCLES    = PHASE_A_CYCLES + 3 * PHASE_B_CYCLES
                                    + 4 * STALL_CYCLES + FILL_CYCLES + TAIL_CYCLES;
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + DRAIN_CYCLES * NUM_PHASES;

    localparam logic [31:0] LFSR_SEED = 32'h3b825418;
    // x^32 + x^31 + x^29 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'hd0000001;

    // ====================
    // DUT and clock
    // ====================

    logic       rd_clk_rd_mgated = 1'b0;
    logic       wr_reset_;
    logic       wr_req;
    fifo_data_t wr_data;
    fifo_cnt_t  wr_limit;
    logic       wr_ready;
    logic       rd_ready;
    logic       rd_req;
    fifo_data_t rd_data;

    // model and bookkeeping
    fifo_data_t  model_q [$];
    logic [31:0] lfsr_state = LFSR_SEED;
    int          eff_limit = FIFO_DEPTH;
    int          mismatch_count = 0;
    int          other_count = 0;
    int          cycle_count = 0;
    int          max_outstanding = 0;
    logic        checks_on = 1'b0;
    logic        was_stalled = 1'b0;
    fifo_data_t  held_data;

    csb_fifo_top i_dut (
        .rd_clk_rd_mgated (rd_clk_rd_mgated),
        .wr_reset_        (wr_reset_),
        .wr_req           (wr_req),
        .wr_data          (wr_data),
        .wr_limit         (wr_limit),
        .wr_ready         (wr_ready),
        .rd_ready         (rd_ready),
        .rd_req           (rd_req),
        .rd_data          (rd_data)
    );

    always #4 rd_clk_rd_mgated = ~rd_clk_rd_mgated;

    // watchdog on total run length
    always @(posedge rd_clk_rd_mgated) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            print_counts();
            $display("Something failed");
            $finish;
        end
    end

    // ====================
    // random bits
    // ====================

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // one step per bit
    function automatic logic take_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        return b;
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[62:0], take_bit()};
        end
        return v;
    endfunction

    // zero and 4..7 both select the whole RAM
    function automatic int effective_limit(input fifo_cnt_t lim);
        if (lim == '0 || int'(lim) >= FIFO_DEPTH) begin
            return FIFO_DEPTH;
        end
        return int'(lim);
    endfunction

    // ====================
    // checking
    // ====================

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            mismatch_count++;
        end
    endtask

    task automatic print_counts();
        $write("summary: %0d value mismatches, %0d other errors, ",
               mismatch_count, other_count);
        $display("%0d assertion failures, %0d cycles, %0d max outstanding",
                 i_dut.u_assertions.fail_count, cycle_count, max_outstanding);
    endtask

    // handshakes seen at this edge use values from before the edge
    task automatic sample_edge();
        fifo_data_t expected;
        if (was_stalled) begin
            check_value("rd_req", 64'(rd_req), 64'(1'b1));
            check_value("rd_data", 64'(rd_data), 64'(held_data));
        end
        if (rd_req && rd_ready) begin
            if (model_q.size() == 0) begin
                $display("t=%0t: word delivered with nothing outstanding", $time);
                other_count++;
            end else begin
                expected = model_q.pop_front();
                check_value("rd_data", 64'(rd_data), 64'(expected));
            end
        end
        if (wr_req && wr_ready) begin
            model_q.push_back(wr_data);
        end
        was_stalled = rd_req && !rd_ready;
        held_data = rd_data;
        // limit in RAM plus one in the output register and one waiting
        if (model_q.size() > eff_limit + 2) begin
            $display("t=%0t: %0d items outstanding, more than limit %0d plus two",
                     $time, model_q.size(), eff_limit);
            other_count++;
        end
        if (model_q.size() > max_outstanding) begin
            max_outstanding = model_q.size();
        end
    endtask

    task automatic next_edge();
        @(posedge rd_clk_rd_mgated);
        if (checks_on) begin
            sample_edge();
        end
    endtask

    // ====================
    // stimulus
    // ====================

    // pre-reset items vanish from the model
    task automatic apply_reset();
        wr_reset_ <= 1'b0;
        wr_req <= 1'b0;
        rd_ready <= 1'b0;
        checks_on = 1'b0;
        was_stalled = 1'b0;
        model_q.delete();
        repeat (RESET_CYCLES) @(posedge rd_clk_rd_mgated);
        wr_reset_ <= 1'b1;
        @(posedge rd_clk_rd_mgated);
        check_value("rd_req", 64'(rd_req), 64'(1'b0));
        check_value("wr_ready", 64'(wr_ready), 64'(1'b1));
        checks_on = 1'b1;
    endtask

    task automatic set_limit(input fifo_cnt_t lim);
        wr_limit <= lim;
        eff_limit = effective_limit(lim);
    endtask

    // requests three quarters of the time and reads half
    task automatic run_random(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            next_edge();
            wr_req   <= (take_bits(2) != 64'd0);
            rd_ready <= take_bit();
            wr_data  <= fifo_data_t'(take_bits(DATA_W));
        end
    endtask

    // consumer stalled while the source keeps pushing
    task automatic run_stall(input int cycles);
        wr_req <= 1'b1;
        rd_ready <= 1'b0;
        for (int c = 0; c < cycles; c++) begin
            next_edge();
            wr_data <= fifo_data_t'(take_bits(DATA_W));
            if (c >= STALL_CHECK) begin
                check_value("wr_ready", 64'(wr_ready), 64'(1'b0));
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        wr_req <= 1'b0;
        rd_ready <= 1'b1;
        while (model_q.size() != 0 && waited < DRAIN_CYCLES) begin
            next_edge();
            waited++;
        end
        if (model_q.size() != 0) begin
            $display("t=%0t: FIFO did not drain in %0d cycles, %0d items left",
                     $time, DRAIN_CYCLES, model_q.size());
            other_count++;
        end
        // nothing more may show up
        repeat (3) next_edge();
    endtask

    // ====================
    // test sequence
    // ====================

    initial begin
        fifo_cnt_t full_lim;
        wr_reset_ <= 1'b0;
        wr_req    <= 1'b0;
        wr_data   <= '0;
        wr_limit  <= '0;
        rd_ready  <= 1'b0;
        apply_reset();

        // phase A runs at full depth under one of its encodings
        full_lim = fifo_cnt_t'(take_bits(CNT_W));
        if (full_lim != '0 && int'(full_lim) < FIFO_DEPTH) begin
            full_lim = '0;
        end
        set_limit(full_lim);
        run_random(PHASE_A_CYCLES);
        drain();

        // phase B with reduced limits
        for (int lim = 1; lim < FIFO_DEPTH; lim++) begin
            apply_reset();
            set_limit(fifo_cnt_t'(lim));
            run_random(PHASE_B_CYCLES);
            drain();
        end

        // phase C stalls then drains at every limit
        for (int lim = 0; lim < FIFO_DEPTH; lim++) begin
            apply_reset();
            set_limit(fifo_cnt_t'(lim));
            run_stall(STALL_CYCLES);
            drain();
        end

        // reset with the FIFO full so old words must not come out
        apply_reset();
        set_limit('0);
        run_stall(FILL_CYCLES);
        apply_reset();
        run_random(TAIL_CYCLES);
        drain();

        print_counts();
        if (mismatch_count == 0 && other_count == 0 &&
            i_dut.u_assertions.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
source/csb_fifo_pkg.sv
source/fifo_wr_ctrl.sv
source/fifo_flop_ram.sv
source/fifo_rd_stage.sv
source/csb_fifo_top.sv
tests/csb_fifo_assertions.sv
tests/csb_fifo_tb.sv

// File: Makefile
# Verilator build and run of the control-bus FIFO testbench

VERILATOR ?= verilator
TOP       ?= csb_fifo_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0 -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Something failed
PASS_MSG  ?= Everything OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)

check: run
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
